//--- hw/appleTracker.sv
`timescale 1ns/100ps

module appleTracker
(
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 checkHit,
    input  snakePkg::xCoord      headX,
    input  snakePkg::yCoord      headY,
    output snakePkg::xCoord      appleX,
    output snakePkg::yCoord      appleY,
    output snakePkg::scoreCount  score,
    output logic                 appleEaten
);
    import snakePkg::*;

    logic [appleIndexBits-1:0] appleIndex;
    logic headOnApple;
    logic eatNow;

    // current apple from the table
    assign appleX = appleTableX[appleIndex];
    assign appleY = appleTableY[appleIndex];

    assign headOnApple = blocksOverlap(headX, headY, blockSize, appleX, appleY, appleSize);
    assign eatNow = checkHit && headOnApple;

    // table position, wraps after the last entry
    always_ff @(posedge Clock)
    begin
        if (reset)
            appleIndex <= '0;
        else if (eatNow)
        begin
            if (appleIndex == appleIndexBits'(appleCount - 1))
                appleIndex <= '0;
            else
                appleIndex <= appleIndex + 1'b1;
        end
    end

    // apples eaten, wraps at 16
    always_ff @(posedge Clock)
    begin
        if (reset)
            score <= '0;
        else if (eatNow)
            score <= score + 1'b1;
    end

    // one cycle after the check, same time as bodyHit
    always_ff @(posedge Clock)
    begin
        if (reset)
            appleEaten <= 1'b0;
        else
            appleEaten <= eatNow;
    end

endmodule

//--- hw/frameSequencer.sv
`timescale 1ns/100ps

module frameSequencer
(
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 moveRight,
    input  logic                 moveDown,
    input  logic                 moveUp,
    input  logic                 moveLeft,
    input  snakePkg::pixelColour playerColour,
    input  snakePkg::xCoord      segmentX,
    input  snakePkg::yCoord      segmentY,
    input  snakePkg::xCoord      appleX,
    input  snakePkg::yCoord      appleY,
    input  logic                 bodyHit,
    input  logic                 appleEaten,
    output logic                 bodyStep,
    output logic                 checkHit,
    output logic [2:0]           segmentIndex,
    output snakePkg::direction   stepDirection,
    output snakePkg::xCoord      pixelX,
    output snakePkg::yCoord      pixelY,
    output snakePkg::pixelColour pixelColourOut,
    output logic                 plot,
    output logic                 gameOver
);
    import snakePkg::*;

    gameState state;
    gameState nextState;
    logic [stepPeriodBits-1:0] stepTimer;
    logic tick;
    logic [3:0] scanCol;
    logic [3:0] scanRow;
    logic [3:0] scanEdge;
    logic blockDone;
    logic lastSegment;
    logic anyKey;
    logic firstFrameDone;
    direction keyDirection;
    direction pressedDirection;
    xCoord shownAppleX;
    yCoord shownAppleY;
    xCoord originX;
    yCoord originY;

    // free-running step timer
    always_ff @(posedge Clock)
    begin
        if (reset)
            stepTimer <= '0;
        else
            stepTimer <= stepTimer + 1'b1;
    end

    assign tick = (stepTimer == '0);

    // key priority right, down, up, left
    assign anyKey = moveRight | moveDown | moveUp | moveLeft;

    always_comb
    begin
        if (moveRight)
            keyDirection = right;
        else if (moveDown)
            keyDirection = down;
        else if (moveUp)
            keyDirection = up;
        else if (moveLeft)
            keyDirection = left;
        else
            keyDirection = none;
    end

    // last key pressed, and the copy the body steps with
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            pressedDirection <= none;
            stepDirection <= none;
            firstFrameDone <= 1'b0;
        end
        else
        begin
            if (anyKey)
                pressedDirection <= keyDirection;
            if (state == move && !bodyHit)
                stepDirection <= pressedDirection;
            if (state == waitKey && anyKey)
                firstFrameDone <= 1'b1;
        end
    end

    assign plot = (state == drawApple) || (state == drawBody)
               || (state == eraseBody) || (state == eraseApple);
    assign scanEdge = (state == drawApple || state == eraseApple) ? 4'(appleSize) : 4'(blockSize);
    assign blockDone = plot && (scanCol == scanEdge - 1'b1) && (scanRow == scanEdge - 1'b1);
    assign lastSegment = (segmentIndex == 3'(segmentCount - 1));

    // raster scan inside the current block
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            scanCol <= '0;
            scanRow <= '0;
            segmentIndex <= '0;
        end
        else if (plot)
        begin
            if (scanCol == scanEdge - 1'b1)
            begin
                scanCol <= '0;
                if (scanRow == scanEdge - 1'b1)
                    scanRow <= '0;
                else
                    scanRow <= scanRow + 1'b1;
            end
            else
                scanCol <= scanCol + 1'b1;
            if (blockDone && (state == drawBody || state == eraseBody))
                segmentIndex <= lastSegment ? 3'd0 : segmentIndex + 1'b1;
        end
    end

    // the apple on screen, so an eaten one is erased where it was drawn
    always_ff @(posedge Clock)
    begin
        if (state == drawApple)
        begin
            shownAppleX <= appleX;
            shownAppleY <= appleY;
        end
    end

    always_comb
    begin
        originX = segmentX;
        originY = segmentY;
        pixelColourOut = playerColour;
        case (state)
            drawApple:
            begin
                originX = appleX;
                originY = appleY;
                pixelColourOut = appleColour;
            end
            eraseApple:
            begin
                originX = shownAppleX;
                originY = shownAppleY;
                pixelColourOut = eraseColour;
            end
            eraseBody:
                pixelColourOut = eraseColour;
            default:
                ;
        endcase
    end

    assign pixelX = originX + xCoord'(scanCol);
    assign pixelY = originY + yCoord'(scanRow);

    always_comb
    begin
        nextState = state;
        case (state)
            idle:
                if (start && tick)
                    nextState = drawApple;
            drawApple:
                if (blockDone)
                    nextState = drawBody;
            drawBody:
                if (blockDone && lastSegment)
                    nextState = firstFrameDone ? waitTick : waitKey;
            waitKey:
                if (anyKey)
                    nextState = waitTick;
            waitTick:
                if (tick)
                    nextState = eraseBody;
            eraseBody:
                if (blockDone && lastSegment)
                    nextState = snakePkg::checkHit;
            snakePkg::checkHit:
                nextState = move;
            move:
            begin
                if (bodyHit)
                    nextState = over;
                else if (appleEaten)
                    nextState = eraseApple;
                else
                    nextState = shift;
            end
            eraseApple:
                if (blockDone)
                    nextState = shift;
            shift:
                nextState = drawApple;
            over:
                nextState = over;
            default:
                nextState = idle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            state <= idle;
        else
            state <= nextState;
    end

    assign checkHit = (state == snakePkg::checkHit);
    assign bodyStep = (state == shift);
    assign gameOver = (state == over);

endmodule

//--- hw/snakeBody.sv
`timescale 1ns/100ps

module snakeBody
(
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 bodyStep,
    input  logic                 checkHit,
    input  logic [2:0]           segmentIndex,
    input  snakePkg::direction   stepDirection,
    output snakePkg::xCoord      headX,
    output snakePkg::yCoord      headY,
    output snakePkg::xCoord      segmentX,
    output snakePkg::yCoord      segmentY,
    output logic                 bodyHit
);
    import snakePkg::*;

    // entry 0 is the head, each later entry one step older
    xCoord historyX [historyDepth];
    yCoord historyY [historyDepth];
    xCoord nextX;
    yCoord nextY;
    logic anyHit;

    assign headX = historyX[0];
    assign headY = historyY[0];

    // head counters, one pixel per step
    always_comb
    begin
        nextX = historyX[0];
        nextY = historyY[0];
        case (stepDirection)
            right:
                nextX = historyX[0] + 8'd1;
            left:
                nextX = historyX[0] - 8'd1;
            down:
                nextY = historyY[0] + 7'd1;
            up:
                nextY = historyY[0] - 7'd1;
            default:
                ;
        endcase
    end

    // position history, shifted once per step
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // segment i starts blockSize rows below segment i-1
            for (int k = 0; k < historyDepth; k++)
            begin
                historyX[k] <= startX;
                historyY[k] <= startY + yCoord'((k / blockSize) * blockSize);
            end
        end
        else if (bodyStep)
        begin
            historyX[0] <= nextX;
            historyY[0] <= nextY;
            for (int k = 1; k < historyDepth; k++)
            begin
                historyX[k] <= historyX[k - 1];
                historyY[k] <= historyY[k - 1];
            end
        end
    end

    // one segment every blockSize entries
    always_comb
    begin
        segmentX = historyX[0];
        segmentY = historyY[0];
        for (int i = 1; i < segmentCount; i++)
        begin
            if (segmentIndex == 3'(i))
            begin
                segmentX = historyX[i * blockSize];
                segmentY = historyY[i * blockSize];
            end
        end
    end

    // segments 0 and 1 always touch the head, so start higher
    always_comb
    begin
        anyHit = 1'b0;
        for (int i = firstHitSegment; i < segmentCount; i++)
        begin
            if (blocksOverlap(historyX[0], historyY[0], blockSize,
                              historyX[i * blockSize], historyY[i * blockSize], blockSize))
                anyHit = 1'b1;
        end
    end

    // result held until the next check
    always_ff @(posedge Clock)
    begin
        if (reset)
            bodyHit <= 1'b0;
        else if (checkHit)
            bodyHit <= anyHit;
    end

endmodule

//--- hw/snakeGame.sv
`timescale 1ns/100ps

module snakeGame
(
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 moveRight,
    input  logic                 moveDown,
    input  logic                 moveUp,
    input  logic                 moveLeft,
    input  snakePkg::pixelColour playerColour,
    output snakePkg::xCoord      pixelX,
    output snakePkg::yCoord      pixelY,
    output snakePkg::pixelColour pixelColourOut,
    output logic                 plot,
    output snakePkg::scoreCount  score,
    output logic                 gameOver
);
    import snakePkg::*;

    logic bodyStep;
    logic checkHit;
    logic [2:0] segmentIndex;
    direction stepDirection;
    xCoord headX;
    yCoord headY;
    xCoord segmentX;
    yCoord segmentY;
    logic bodyHit;
    xCoord appleX;
    yCoord appleY;
    logic appleEaten;

    snakeBody body
    (
        .Clock(Clock),
        .reset(reset),
        .bodyStep(bodyStep),
        .checkHit(checkHit),
        .segmentIndex(segmentIndex),
        .stepDirection(stepDirection),
        .headX(headX),
        .headY(headY),
        .segmentX(segmentX),
        .segmentY(segmentY),
        .bodyHit(bodyHit)
    );

    appleTracker apple
    (
        .Clock(Clock),
        .reset(reset),
        .checkHit(checkHit),
        .headX(headX),
        .headY(headY),
        .appleX(appleX),
        .appleY(appleY),
        .score(score),
        .appleEaten(appleEaten)
    );

    frameSequencer sequencer
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .moveRight(moveRight),
        .moveDown(moveDown),
        .moveUp(moveUp),
        .moveLeft(moveLeft),
        .playerColour(playerColour),
        .segmentX(segmentX),
        .segmentY(segmentY),
        .appleX(appleX),
        .appleY(appleY),
        .bodyHit(bodyHit),
        .appleEaten(appleEaten),
        .bodyStep(bodyStep),
        .checkHit(checkHit),
        .segmentIndex(segmentIndex),
        .stepDirection(stepDirection),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColourOut(pixelColourOut),
        .plot(plot),
        .gameOver(gameOver)
    );

endmodule

//--- hw/snakePkg.sv
package snakePkg;

    // playing field, in pixels
    localparam int fieldWidth = 160;
    localparam int fieldHeight = 120;

    localparam int blockSize = 10;
    localparam int appleSize = 4;
    localparam int segmentCount = 6;
    localparam int historyDepth = segmentCount * blockSize;
    localparam int firstHitSegment = 2;
    localparam int stepPeriodBits = 4;

    typedef logic [$clog2(fieldWidth)-1:0] xCoord;
    typedef logic [$clog2(fieldHeight)-1:0] yCoord;
    typedef logic [2:0] pixelColour;
    typedef logic [3:0] scoreCount;

    // head origin, the rest of the body hangs below it
    localparam xCoord startX = 8'd80;
    localparam yCoord startY = 7'd60;

    // apple places, visited in order and wrapping
    localparam int appleCount = 7;
    localparam int appleIndexBits = $clog2(appleCount);
    localparam xCoord appleTableX [appleCount] = '{8'd30, 8'd10, 8'd70, 8'd60, 8'd20, 8'd50, 8'd80};
    localparam yCoord appleTableY [appleCount] = '{7'd30, 7'd20, 7'd90, 7'd100, 7'd80, 7'd10, 7'd50};

    localparam pixelColour appleColour = 3'b100;
    localparam pixelColour eraseColour = 3'b000;

    typedef enum logic [2:0] {none, right, down, up, left} direction;

    typedef enum logic [3:0] {idle, drawApple, drawBody, waitKey, waitTick, eraseBody,
                              checkHit, move, eraseApple, shift, over} gameState;

    // true when two square blocks share at least one pixel
    function automatic logic blocksOverlap(input xCoord aX, input yCoord aY, input int aSize,
                                           input xCoord bX, input yCoord bY, input int bSize);
        return (int'(aX) < int'(bX) + bSize) && (int'(bX) < int'(aX) + aSize)
            && (int'(aY) < int'(bY) + bSize) && (int'(bY) < int'(aY) + aSize);
    endfunction

endpackage

//--- tests/clockGen.sv
`timescale 1ns/100ps

module clockGen
(
    output logic Clock,
    output logic reset
);
    // 40 ns period
    initial
    begin
        Clock = 1'b0;
        forever
            #20 Clock = ~Clock;
    end

    // reset held for five rising edges, released on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (5)
            @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
    end

endmodule

//--- tests/pixelChecker.sv
`timescale 1ns/100ps

module pixelChecker
(
    input  logic       Clock,
    input  logic       reset,
    input  logic       moveRight,
    input  logic       moveDown,
    input  logic       moveUp,
    input  logic       moveLeft,
    input  logic [2:0] playerColour,
    input  logic [7:0] pixelX,
    input  logic [6:0] pixelY,
    input  logic [2:0] pixelColourOut,
    input  logic       plot,
    input  logic [3:0] score,
    input  logic       gameOver,
    output int         frameCount,
    output int         modelScore,
    output logic       modelOver,
    output int         errorCount
);
    // apple places in the order they are visited
    localparam int tableX [7] = '{30, 10, 70, 60, 20, 50, 80};
    localparam int tableY [7] = '{30, 20, 90, 100, 80, 10, 50};

    // entry 0 is the head, ten entries per segment
    int histX [60];
    int histY [60];
    int appleIndex;
    int erasedIndex;
    int heldDir;
    // 0 apple draw, 1 body draw, 2 body erase, 3 apple erase, 4 ended
    int phase;
    int count;

    // blocks share a pixel unless one lies fully beside the other
    function automatic bit overlapping(int ax, int ay, int aSize, int bx, int by, int bSize);
        return !(ax >= bx + bSize || bx >= ax + aSize || ay >= by + bSize || by >= ay + aSize);
    endfunction

    task automatic compare(string name, int got, int expected);
        if (got != expected)
        begin
            errorCount++;
            $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic expectPixel(output int ex, output int ey, output int ec);
        int seg;
        int off;
        seg = count / 100;
        off = count % 100;
        ex = histX[seg * 10] + off % 10;
        ey = histY[seg * 10] + off / 10;
        ec = (phase == 1) ? int'(playerColour) : 0;
        if (phase == 0)
        begin
            ex = tableX[appleIndex] + count % 4;
            ey = tableY[appleIndex] + count / 4;
            ec = 3'b100;
        end
        else if (phase == 3)
        begin
            ex = tableX[erasedIndex] + count % 4;
            ey = tableY[erasedIndex] + count / 4;
            ec = 0;
        end
    endtask

    task automatic stepSnake();
        for (int k = 59; k > 0; k--)
        begin
            histX[k] = histX[k - 1];
            histY[k] = histY[k - 1];
        end
        case (heldDir)
            1: histX[0] = histX[0] + 1;
            2: histY[0] = histY[0] + 1;
            3: histY[0] = histY[0] - 1;
            4: histX[0] = histX[0] - 1;
            default: ;
        endcase
        phase = 0;
    endtask

    // collision and apple rules on the head that was just drawn
    task automatic judgeStep();
        bit hit;
        bit eaten;
        hit = 0;
        for (int i = 2; i < 6; i++)
        begin
            if (overlapping(histX[0], histY[0], 10, histX[i * 10], histY[i * 10], 10))
                hit = 1;
        end
        eaten = overlapping(histX[0], histY[0], 10, tableX[appleIndex], tableY[appleIndex], 4);
        if (eaten)
        begin
            modelScore = (modelScore + 1) % 16;
            erasedIndex = appleIndex;
            appleIndex = (appleIndex + 1) % 7;
        end
        if (hit)
        begin
            modelOver = 1'b1;
            phase = 4;
        end
        else if (eaten)
            phase = 3;
        else
            stepSnake();
    endtask

    task automatic checkPixel();
        int ex;
        int ey;
        int ec;
        int phaseLength;
        expectPixel(ex, ey, ec);
        compare("pixelX", pixelX, ex);
        compare("pixelY", pixelY, ey);
        compare("pixelColourOut", pixelColourOut, ec);
        compare("score", score, modelScore);
        compare("gameOver", gameOver, 0);
        count++;
        phaseLength = (phase == 0 || phase == 3) ? 16 : 600;
        if (count == phaseLength)
        begin
            count = 0;
            case (phase)
                0: phase = 1;
                1:
                begin
                    frameCount++;
                    phase = 2;
                end
                2: judgeStep();
                default: stepSnake();
            endcase
        end
    endtask

    always @(posedge Clock)
    begin
        if (reset)
        begin
            for (int k = 0; k < 60; k++)
            begin
                histX[k] = 80;
                histY[k] = 60 + (k / 10) * 10;
            end
            appleIndex = 0;
            erasedIndex = 0;
            heldDir = 0;
            phase = 0;
            count = 0;
            frameCount = 0;
            modelScore = 0;
            modelOver = 1'b0;
            errorCount = 0;
        end
        else
        begin
            // last key pressed, priority right, down, up, left
            if (moveRight)
                heldDir = 1;
            else if (moveDown)
                heldDir = 2;
            else if (moveUp)
                heldDir = 3;
            else if (moveLeft)
                heldDir = 4;
            if (plot && modelOver)
            begin
                errorCount++;
                $display("a pixel was plotted at %0d ns after the game had ended", $time);
            end
            else if (plot)
                checkPixel();
        end
    end

endmodule

//--- tests/snakeGameTb.sv
`timescale 1ns/100ps

module snakeGameTb;
    import snakePkg::*;

    localparam int maxWords = 64;

    logic Clock;
    logic reset;
    logic start;
    logic moveRight;
    logic moveDown;
    logic moveUp;
    logic moveLeft;
    pixelColour playerColour;
    xCoord pixelX;
    yCoord pixelY;
    pixelColour pixelColourOut;
    logic plot;
    scoreCount score;
    logic gameOver;
    int frameCount;
    int modelScore;
    logic modelOver;
    int checkerErrors;
    int recordErrors;
    int timeouts;
    // four words per record, ff ends the list
    logic [7:0] recordWords [maxWords];

    clockGen clocks
    (
        .Clock(Clock),
        .reset(reset)
    );

    snakeGame snakeGame_inst
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .moveRight(moveRight),
        .moveDown(moveDown),
        .moveUp(moveUp),
        .moveLeft(moveLeft),
        .playerColour(playerColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColourOut(pixelColourOut),
        .plot(plot),
        .score(score),
        .gameOver(gameOver)
    );

    pixelChecker pixelCheck
    (
        .Clock(Clock),
        .reset(reset),
        .moveRight(moveRight),
        .moveDown(moveDown),
        .moveUp(moveUp),
        .moveLeft(moveLeft),
        .playerColour(playerColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColourOut(pixelColourOut),
        .plot(plot),
        .score(score),
        .gameOver(gameOver),
        .frameCount(frameCount),
        .modelScore(modelScore),
        .modelOver(modelOver),
        .errorCount(checkerErrors)
    );

    task automatic compareResult(string name, int got, int expected);
        if (got != expected)
        begin
            recordErrors++;
            $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // code 0 releases all keys
    task automatic holdDirection(int code);
        moveRight = (code == 1);
        moveDown = (code == 2);
        moveUp = (code == 3);
        moveLeft = (code == 4);
    endtask

    initial
    begin
        int r;
        int target;
        int waited;
        start = 1'b0;
        holdDirection(0);
        playerColour = 3'b010;
        recordErrors = 0;
        timeouts = 0;
        $readmemh("tests/snakeGame_input.txt", recordWords);
        waited = 0;
        do
        begin
            @(negedge Clock);
            waited++;
        end
        while (reset && waited < 20);
        if (reset)
        begin
            timeouts++;
            $display("reset was never released");
        end
        // idle with start low
        for (int n = 0; n < 40; n++)
        begin
            @(negedge Clock);
            compareResult("plot", plot, 0);
            compareResult("gameOver", gameOver, 0);
            compareResult("score", score, 0);
        end
        r = 0;
        while (timeouts == 0 && r * 4 < maxWords && recordWords[r * 4] != 8'hff)
        begin
            @(negedge Clock);
            holdDirection(recordWords[r * 4]);
            start = 1'b1;
            target = frameCount + recordWords[r * 4 + 1];
            waited = 0;
            while (frameCount < target && !gameOver
                   && waited < (recordWords[r * 4 + 1] + 2) * 1400)
            begin
                @(negedge Clock);
                waited++;
            end
            if (frameCount < target && !gameOver)
            begin
                timeouts++;
                $display("record %0d timed out waiting for its frames", r);
            end
            else
            begin
                compareResult("score", score, recordWords[r * 4 + 2]);
                compareResult("gameOver", gameOver, recordWords[r * 4 + 3]);
                compareResult("model score", modelScore, recordWords[r * 4 + 2]);
                compareResult("model gameOver", modelOver, recordWords[r * 4 + 3]);
            end
            r++;
        end
        // quiet tail, a stray pixel after the end would show here
        repeat (2000)
            @(negedge Clock);
        // an ended game stays ended
        compareResult("gameOver", gameOver, modelOver);
        $display("errors: checker %0d, records %0d, timeouts %0d, assertions %0d",
                 checkerErrors, recordErrors, timeouts,
                 snakeGame_inst.outputChecks.failCount);
        if (checkerErrors + recordErrors + timeouts
            + snakeGame_inst.outputChecks.failCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tests/snakeGame_asserts.sv
`timescale 1ns/100ps

module snakeGame_asserts
(
    input logic                Clock,
    input logic                reset,
    input logic                plot,
    input snakePkg::xCoord     pixelX,
    input snakePkg::yCoord     pixelY,
    input snakePkg::scoreCount score,
    input logic                gameOver
);
    import snakePkg::*;

    int failCount = 0;

    pixelOnField: assert property (@(posedge Clock) disable iff (reset)
        plot |-> (int'(pixelX) < fieldWidth) && (int'(pixelY) < fieldHeight))
        else
        begin
            failCount++;
            $error("pixel outside the field at %0d, %0d", pixelX, pixelY);
        end

    // an apple is counted between frames, never while pixels stream out
    scoreQuietWhilePlotting: assert property (@(posedge Clock) disable iff (reset)
        plot |-> $stable(score))
        else
        begin
            failCount++;
            $error("score changed from %0d to %0d during a frame", $past(score), score);
        end

    // no apple is eaten once the game has ended
    scoreFrozenWhenOver: assert property (@(posedge Clock) disable iff (reset)
        gameOver |-> $stable(score))
        else
        begin
            failCount++;
            $error("score changed from %0d to %0d after the game ended", $past(score), score);
        end

endmodule

bind snakeGame snakeGame_asserts outputChecks
(
    .Clock(Clock),
    .reset(reset),
    .plot(plot),
    .pixelX(pixelX),
    .pixelY(pixelY),
    .score(score),
    .gameOver(gameOver)
);

//--- tests/snakeGame_input.txt
// direction (0 none held, 1 right, 2 down, 3 up, 4 left), frames to hold it,
// expected score, expected gameOver; all hex, ff ends the list
4 20 0 0
4 10 0 0
3 10 0 0
0 0e 1 0
2 0a 1 1
ff 00 0 0

//--- verilog.f
hw/snakePkg.sv
hw/snakeBody.sv
hw/appleTracker.sv
hw/frameSequencer.sv
hw/snakeGame.sv
tests/clockGen.sv
tests/pixelChecker.sv
tests/snakeGame_asserts.sv
tests/snakeGameTb.sv
